// File: compile.f
+incdir+include
logic/rv32_decode_pkg.sv
logic/rvc_checker.sv
logic/alu_lsu_decoder.sv
logic/sys_decoder.sv
logic/rv32i_decode_stage.sv
verification/tb_decode_stage.sv

// File: Makefile
TOP := tb_decode_stage

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f logic/*.sv include/*.svh verification/*.sv
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Test OK" sim.log

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: include/decode_ref.svh
//////////////////////////////////////////////////
// decode reference model
// expected control bundle for any fetched word
//////////////////////////////////////////////////

`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// reserved or unsupported compressed encodings
function automatic logic ref_rvc_illegal(input logic [31:0] w);
  logic [2:0] f3;
  f3 = w[15:13];
  case (w[1:0])
    2'b00:   return ((f3 == 3'b000) && (w[12:5] == 8'h00)) ||
                    ((f3 != 3'b000) && (f3 != 3'b010) && (f3 != 3'b110));
    2'b01:   return ((f3 == 3'b011) && ({w[12], w[6:2]} == 6'h00)) ||
                    ((f3 == 3'b100) && w[12] && (w[11:10] != 2'b10));
    2'b10:   return ((f3 == 3'b000) && w[12]) || f3[0] ||
                    ((f3 == 3'b010) && (w[11:7] == 5'd0)) ||
                    ((f3 == 3'b100) && !w[12] && (w[11:2] == 10'd0));
    default: return 1'b0;
  endcase
endfunction

// full expected bundle, debug levels as seen with the word
function automatic decoder_ctrl_t ref_decode(input logic [31:0] w, input logic dbg,
                                             input logic no_sleep);
  decoder_ctrl_t c;
  logic [2:0]    f3;
  logic [6:0]    f7;
  alu_op_e       ops[8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                            ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
  alu_op_e       bch[8] = '{ALU_EQ, ALU_NE, ALU_EQ, ALU_EQ,
                            ALU_LT, ALU_GE, ALU_LTU, ALU_GEU};
  c  = '0;
  f3 = w[14:12];
  f7 = w[31:25];
  if (w[1:0] != 2'b11) begin
    c.illegal_insn = ref_rvc_illegal(w);
    return c;
  end
  case (w[6:0])
    OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL: begin
      c.alu_en  = 1'b1;
      c.rf_we   = 1'b1;
      c.alu_jmp = (w[6:0] == OPCODE_JAL);
    end
    OPCODE_JALR: begin
      if (f3 != 3'b000) return DECODER_CTRL_ILLEGAL;
      {c.alu_en, c.alu_jmp, c.alu_jmpr, c.rf_we, c.rf_re} = 6'b111101;
    end
    OPCODE_BRANCH: begin
      if (f3[2:1] == 2'b01) return DECODER_CTRL_ILLEGAL;
      {c.alu_en, c.alu_bch, c.rf_re} = 4'b1111;
      c.alu_operator = bch[f3];
    end
    OPCODE_LOAD, OPCODE_STORE: begin
      if (w[5] && (f3[2] || (f3[1:0] == 2'b11))) return DECODER_CTRL_ILLEGAL;
      if (!w[5] && ((f3 == 3'b011) || (f3[2:1] == 2'b11))) return DECODER_CTRL_ILLEGAL;
      c.lsu_en   = 1'b1;
      c.lsu_we   = w[5];
      c.rf_we    = !w[5];
      c.rf_re    = {w[5], 1'b1};
      c.lsu_size = f3[1:0];
      c.lsu_sext = !w[5] && !f3[2];
    end
    OPCODE_OPIMM, OPCODE_OP: begin
      if ((f3 == 3'b001 || !w[5]) && (f3 != 3'b101) && (f7 != 7'h00) && (w[5] || f3 == 3'b001))
        return DECODER_CTRL_ILLEGAL;
      if ((f3 == 3'b101) && (f7 != 7'h00) && (f7 != 7'h20)) return DECODER_CTRL_ILLEGAL;
      if (w[5] && (f7 != 7'h00) && !((f7 == 7'h20) && (f3 == 3'b000 || f3 == 3'b101)))
        return DECODER_CTRL_ILLEGAL;
      {c.alu_en, c.rf_we} = 2'b11;
      c.rf_re        = {w[5] && !w[28], 1'b1};
      c.alu_operator = ops[f3];
      // op-imm upper bits are immediate, only srai reads them as funct7
      if ((f7 == 7'h20) && (w[5] || (f3 == 3'b101)))
        c.alu_operator = (f3 == 3'b000) ? ALU_SUB : ALU_SRA;
    end
    OPCODE_FENCE: begin
      if (f3[2:1] != 2'b00) return DECODER_CTRL_ILLEGAL;
      {c.sys_en, c.sys_fencei_insn} = 2'b11;
    end
    OPCODE_SYSTEM: begin
      if (f3 == 3'b000) begin
        if ({w[19:15], w[11:7]} != 10'd0) return DECODER_CTRL_ILLEGAL;
        c.sys_en = 1'b1;
        case (w[31:20])
          12'h000: c.sys_ecall_insn = 1'b1;
          12'h001: c.sys_ebrk_insn  = 1'b1;
          12'h302: c.sys_mret_insn  = 1'b1;
          12'h7b2: begin
            if (dbg) c.sys_dret_insn = 1'b1;
            else     return DECODER_CTRL_ILLEGAL;
          end
          12'h105: c.sys_wfi_insn = !no_sleep;
          default: return DECODER_CTRL_ILLEGAL;
        endcase
      end else begin
        if (f3[1:0] == 2'b00) return DECODER_CTRL_ILLEGAL;
        {c.csr_en, c.rf_we} = 2'b11;
        c.rf_re[0] = !f3[2];
        if (f3[1:0] == 2'b01)    c.csr_op = CSR_OP_WRITE;
        else if (w[19:15] == 0)  c.csr_op = CSR_OP_READ;
        else                     c.csr_op = f3[0] ? CSR_OP_CLEAR : CSR_OP_SET;
      end
    end
    default: return DECODER_CTRL_ILLEGAL;
  endcase
  return c;
endfunction

`endif

// File: verification/tb_decode_stage.sv
//////////////////////////////////////////////////
// decode stage testbench
// random and directed words through the id/ex stage,
// checked one cycle later against the reference model
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_decode_stage import rv32_decode_pkg::*; ();

  `include "decode_ref.svh"

  localparam int unsigned CYCLE_LIMIT = 6000;           // stimulus needs about 4500
  localparam logic [31:0] SEED        = 32'h6587_ecb8;
  localparam logic [6:0]  OPCODES [12] = '{OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR,
                                           OPCODE_BRANCH, OPCODE_LOAD, OPCODE_STORE,
                                           OPCODE_OPIMM, OPCODE_OP, OPCODE_FENCE,
                                           OPCODE_SYSTEM, 7'h5b};  // last one is unknown

  logic          clk = 1'b0;
  logic          rst_n;
  logic          instr_valid;
  logic [31:0]   instr;
  logic          dbg_mode;
  logic          dbg_no_sleep;
  logic          ctrl_valid;
  decoder_ctrl_t act;        // dut outputs gathered back into a bundle
  decoder_ctrl_t exp_d;      // reference for the word on the inputs now
  decoder_ctrl_t prev_exp;   // reference for last cycle's word
  logic [31:0]   prev_word;
  logic [31:0]   rng;
  int unsigned   err_cnt;
  int unsigned   assert_cnt;
  int unsigned   cycle_cnt;

  always #4 clk = ~clk;  // 8 ns period

  rv32i_decode_stage DUT (
    .clk                  (clk),
    .rst_n_i              (rst_n),
    .instr_valid_i        (instr_valid),
    .instr_rdata_i        (instr),
    .debug_mode_i         (dbg_mode),
    .debug_wfi_no_sleep_i (dbg_no_sleep),
    .ctrl_valid_o         (ctrl_valid),
    .illegal_insn_o       (act.illegal_insn),
    .alu_en_o             (act.alu_en),
    .alu_operator_o       (act.alu_operator),
    .alu_bch_o            (act.alu_bch),
    .alu_jmp_o            (act.alu_jmp),
    .alu_jmpr_o           (act.alu_jmpr),
    .rf_we_o              (act.rf_we),
    .rf_re_o              (act.rf_re),
    .lsu_en_o             (act.lsu_en),
    .lsu_we_o             (act.lsu_we),
    .lsu_size_o           (act.lsu_size),
    .lsu_sext_o           (act.lsu_sext),
    .csr_en_o             (act.csr_en),
    .csr_op_o             (act.csr_op),
    .sys_en_o             (act.sys_en),
    .sys_ecall_o          (act.sys_ecall_insn),
    .sys_ebrk_o           (act.sys_ebrk_insn),
    .sys_mret_o           (act.sys_mret_insn),
    .sys_dret_o           (act.sys_dret_insn),
    .sys_wfi_o            (act.sys_wfi_insn),
    .sys_fencei_o         (act.sys_fencei_insn)
  );

  assign exp_d = ref_decode(instr, dbg_mode, dbg_no_sleep);  // debug levels travel with the word

  always @(posedge clk) begin
    prev_exp  <= exp_d;
    prev_word <= instr;
  end

  //////////////////////////////////////////////////
  // checks
  a_decode : assert property (@(posedge clk) disable iff (!rst_n)
      instr_valid |=> ctrl_valid && (act == prev_exp))
    else begin
      err_cnt++;
      $display("Error @ %0t: word %h decoded to %h, expected %h", $time,
               $sampled(prev_word), $sampled(act), $sampled(prev_exp));
    end

  // bubble slot must come out empty
  a_bubble : assert property (@(posedge clk) disable iff (!rst_n)
      !instr_valid |=> !ctrl_valid && (act == '0))
    else begin
      assert_cnt++;
      $display("Error @ %0t: invalid cycle left ctrl_valid or a control bit set", $time);
    end

  a_reset : assert property (@(posedge clk) !rst_n |=> !ctrl_valid && (act == '0))
    else begin
      assert_cnt++;
      $display("Error @ %0t: reset did not clear the id/ex register", $time);
    end

  //////////////////////////////////////////////////
  // stimulus helpers
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng = xorshift32(rng);
    r   = rng;
  endtask

  // random full-size word with its opcode forced
  function automatic logic [31:0] with_opcode(input logic [31:0] r, input logic [6:0] opc,
                                              input logic [6:0] pick);
    logic [31:0] w;
    w = {r[31:7], opc};
    if (((opc == OPCODE_OP) || (opc == OPCODE_OPIMM)) && (pick[1:0] != 2'b00)) begin
      w[31:25] = pick[2] ? 7'h20 : 7'h00;  // mostly legal funct7
    end
    if ((opc == OPCODE_SYSTEM) && pick[6]) w[19:15] = 5'd0;  // csr pure reads
    return w;
  endfunction

  task automatic drive(input logic [31:0] w, input logic v, input logic dbg, input logic ns);
    @(negedge clk);  // inputs move away from the sampling edge
    instr        = w;
    instr_valid  = v;
    dbg_mode     = dbg;
    dbg_no_sleep = ns;
  endtask

  // two opcode groups mixed, optional gaps of invalid cycles
  task automatic send_group(input int n, input logic [6:0] opc_a, input logic [6:0] opc_b,
                            input bit gaps);
    logic [31:0] r;
    logic [31:0] s;
    for (int i = 0; i < n; i++) begin
      next_rand(r);
      next_rand(s);
      drive(with_opcode(r, s[0] ? opc_a : opc_b, s[15:9]), !(gaps && (s[5:3] == 3'b000)),
            s[16], s[17]);
    end
  endtask

  task automatic send_compressed(input int n);
    logic [31:0] r;
    logic [31:0] s;
    for (int i = 0; i < n; i++) begin
      next_rand(r);
      next_rand(s);
      if (r[1:0] == 2'b11) r[1:0] = {1'b0, s[0]};  // fold into quadrant 0 or 1
      drive(r, 1'b1, s[16], s[17]);
    end
  endtask

  // gapless stream over every group
  task automatic send_stream(input int n);
    logic [31:0] r;
    logic [31:0] s;
    logic [31:0] w;
    for (int i = 0; i < n; i++) begin
      next_rand(r);
      next_rand(s);
      if (s[1:0] == 2'b00) w = r;  // raw, mostly compressed
      else                 w = with_opcode(r, OPCODES[int'(s[5:2]) % 12], s[15:9]);
      drive(w, 1'b1, s[16], s[17]);
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  initial begin
    logic [31:0] sys_words [7];
    sys_words    = '{32'h0000_0073, 32'h0010_0073, 32'h3020_0073, 32'h7b20_0073,
                     32'h1050_0073, 32'h0ff0_000f, 32'h0000_100f};  // ecall .. fence.i
    rng          = SEED;
    err_cnt      = 0;
    assert_cnt   = 0;
    rst_n        = 1'b0;
    instr_valid  = 1'b1;  // a valid add under reset must not get through
    instr        = 32'h0000_0033;
    dbg_mode     = 1'b0;
    dbg_no_sleep = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    repeat (8) drive(32'h0000_0033, 1'b0, 1'b0, 1'b0);  // idle after reset
    send_group(400, OPCODE_OP, OPCODE_OPIMM, 1'b1);
    send_group(300, OPCODE_LOAD, OPCODE_STORE, 1'b1);
    send_group(200, OPCODE_BRANCH, OPCODE_JALR, 1'b1);
    send_group(100, OPCODE_JAL, OPCODE_AUIPC, 1'b1);
    for (int d = 0; d < 4; d++) begin  // every debug level pair
      foreach (sys_words[k]) drive(sys_words[k], 1'b1, d[0], d[1]);
    end
    send_group(200, OPCODE_SYSTEM, OPCODE_FENCE, 1'b1);
    send_compressed(200);
    send_stream(3000);
    repeat (3) drive(32'h0000_0013, 1'b0, 1'b0, 1'b0);  // drain the last check

    @(negedge clk);
    $display("decode checks done: %0d value errors, %0d assertion failures",
             err_cnt, assert_cnt);
    if ((err_cnt == 0) && (assert_cnt == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("test timed out after %0d cycles, stimulus never finished", cycle_cnt);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: logic/rv32i_decode_stage.sv
//////////////////////////////////////////////////
// rv32i decode stage
// picks the matching sub-decoder bundle and holds
// the id/ex register, one cycle latency
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rv32i_decode_stage import rv32_decode_pkg::*; (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               instr_valid_i,
  input  logic [INSTR_W-1:0] instr_rdata_i,
  input  logic               debug_mode_i,
  input  logic               debug_wfi_no_sleep_i,
  output logic               ctrl_valid_o,
  output logic               illegal_insn_o,
  output logic               alu_en_o,
  output alu_op_e            alu_operator_o,
  output logic               alu_bch_o,
  output logic               alu_jmp_o,
  output logic               alu_jmpr_o,
  output logic               rf_we_o,
  output logic [1:0]         rf_re_o,
  output logic               lsu_en_o,
  output logic               lsu_we_o,
  output logic [1:0]         lsu_size_o,
  output logic               lsu_sext_o,
  output logic               csr_en_o,
  output csr_op_e            csr_op_o,
  output logic               sys_en_o,
  output logic               sys_ecall_o,
  output logic               sys_ebrk_o,
  output logic               sys_mret_o,
  output logic               sys_dret_o,
  output logic               sys_wfi_o,
  output logic               sys_fencei_o
);

  logic          rvc_match;
  logic          rvc_illegal;
  logic          alu_match;
  decoder_ctrl_t alu_ctrl;
  logic          sys_match;
  decoder_ctrl_t sys_ctrl;
  decoder_ctrl_t ctrl_d;    // selected bundle for this word
  decoder_ctrl_t ctrl_q;    // id/ex register
  logic          valid_q;

  //////////////////////////////////////////////////
  // sub-decoders, all see the same raw word
  rvc_checker u_rvc (
    .instr_rdata_i (instr_rdata_i),
    .rvc_o         (rvc_match),
    .illegal_o     (rvc_illegal)
  );

  alu_lsu_decoder u_alu_lsu (
    .instr_rdata_i (instr_rdata_i),
    .match_o       (alu_match),
    .ctrl_o        (alu_ctrl)
  );

  sys_decoder u_sys (
    .instr_rdata_i        (instr_rdata_i),
    .debug_mode_i         (debug_mode_i),
    .debug_wfi_no_sleep_i (debug_wfi_no_sleep_i),
    .match_o              (sys_match),
    .ctrl_o               (sys_ctrl)
  );

  // priority by match level only, no opcode compare here
  always_comb begin
    if (rvc_match) begin
      ctrl_d              = '0;           // no expansion, legality only
      ctrl_d.illegal_insn = rvc_illegal;
    end else if (alu_match) begin
      ctrl_d = alu_ctrl;
    end else if (sys_match) begin
      ctrl_d = sys_ctrl;
    end else begin
      ctrl_d = DECODER_CTRL_ILLEGAL;      // unknown major opcode
    end
  end

  //////////////////////////////////////////////////
  // id/ex register
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      ctrl_q  <= '0;
    end else begin
      valid_q <= instr_valid_i;
      if (instr_valid_i) ctrl_q <= ctrl_d;
      else               ctrl_q <= '0;    // bubble carries no enables
    end
  end

  assign ctrl_valid_o   = valid_q;
  assign illegal_insn_o = ctrl_q.illegal_insn;
  assign alu_en_o       = ctrl_q.alu_en;
  assign alu_operator_o = ctrl_q.alu_operator;
  assign alu_bch_o      = ctrl_q.alu_bch;
  assign alu_jmp_o      = ctrl_q.alu_jmp;
  assign alu_jmpr_o     = ctrl_q.alu_jmpr;
  assign rf_we_o        = ctrl_q.rf_we;
  assign rf_re_o        = ctrl_q.rf_re;
  assign lsu_en_o       = ctrl_q.lsu_en;
  assign lsu_we_o       = ctrl_q.lsu_we;
  assign lsu_size_o     = ctrl_q.lsu_size;
  assign lsu_sext_o     = ctrl_q.lsu_sext;
  assign csr_en_o       = ctrl_q.csr_en;
  assign csr_op_o       = ctrl_q.csr_op;
  assign sys_en_o       = ctrl_q.sys_en;
  assign sys_ecall_o    = ctrl_q.sys_ecall_insn;
  assign sys_ebrk_o     = ctrl_q.sys_ebrk_insn;
  assign sys_mret_o     = ctrl_q.sys_mret_insn;
  assign sys_dret_o     = ctrl_q.sys_dret_insn;
  assign sys_wfi_o      = ctrl_q.sys_wfi_insn;
  assign sys_fencei_o   = ctrl_q.sys_fencei_insn;

  // execute must never see work in a bubble slot
  a_idle_no_enables : assert property (@(posedge clk) disable iff (!rst_n_i)
    !ctrl_valid_o |-> !(alu_en_o || lsu_en_o || csr_en_o || sys_en_o || rf_we_o))
    else $error("rv32i_decode_stage: enable set while ctrl_valid_o is low");

endmodule

// File: logic/sys_decoder.sv
//////////////////////////////////////////////////
// system decoder
// fences, ecall/ebreak/mret/dret/wfi and csr
// accesses, dret and wfi follow the debug levels
//////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_decoder import rv32_decode_pkg::*; (
  input  logic [INSTR_W-1:0] instr_rdata_i,
  input  logic               debug_mode_i,          // core is halted in debug
  input  logic               debug_wfi_no_sleep_i,  // sleeping not allowed now
  output logic               match_o,
  output decoder_ctrl_t      ctrl_o
);

  logic [2:0] funct3;
  logic [4:0] rs1;  // also the csr uimm

  assign funct3 = instr_rdata_i[14:12];
  assign rs1    = instr_rdata_i[19:15];

  always_comb begin
    ctrl_o              = DECODER_CTRL_ILLEGAL;
    ctrl_o.illegal_insn = 1'b0;
    match_o             = 1'b1;

    unique case (instr_rdata_i[6:0])
      OPCODE_FENCE: begin
        if (funct3[2:1] != 2'b00) begin
          ctrl_o = DECODER_CTRL_ILLEGAL;
        end else begin
          ctrl_o.sys_en          = 1'b1;
          ctrl_o.sys_fencei_insn = 1'b1;  // plain fence takes the fence.i flush too
        end
      end

      OPCODE_SYSTEM: begin
        if (funct3 == 3'b000) begin
          // privileged words, rs1 and rd must be x0
          if ((rs1 != 5'd0) || (instr_rdata_i[11:7] != 5'd0)) begin
            ctrl_o = DECODER_CTRL_ILLEGAL;
          end else begin
            ctrl_o.sys_en = 1'b1;
            unique case (instr_rdata_i[31:20])
              12'h000: ctrl_o.sys_ecall_insn = 1'b1;
              12'h001: ctrl_o.sys_ebrk_insn  = 1'b1;
              12'h302: ctrl_o.sys_mret_insn  = 1'b1;
              12'h7b2: begin
                if (debug_mode_i) ctrl_o.sys_dret_insn = 1'b1;
                else              ctrl_o = DECODER_CTRL_ILLEGAL;  // dret outside debug
              end
              12'h105: ctrl_o.sys_wfi_insn = !debug_wfi_no_sleep_i;  // else acts as a nop
              default: ctrl_o = DECODER_CTRL_ILLEGAL;
            endcase
          end
        end else if (funct3[1:0] == 2'b00) begin
          ctrl_o = DECODER_CTRL_ILLEGAL;  // funct3 100 is not a csr op
        end else begin
          ctrl_o.csr_en   = 1'b1;
          ctrl_o.rf_we    = 1'b1;
          ctrl_o.rf_re[0] = !funct3[2];  // immediate forms read no register
          // set/clear with nothing to apply is a pure read
          if (funct3[1:0] == 2'b01)  ctrl_o.csr_op = CSR_OP_WRITE;
          else if (rs1 == 5'd0)      ctrl_o.csr_op = CSR_OP_READ;
          else if (funct3[0])        ctrl_o.csr_op = CSR_OP_CLEAR;
          else                       ctrl_o.csr_op = CSR_OP_SET;
        end
      end

      default: match_o = 1'b0;
    endcase

    // the controller acts on a single system kind at a time
    assert ($onehot0({ctrl_o.sys_ecall_insn, ctrl_o.sys_ebrk_insn, ctrl_o.sys_mret_insn,
                      ctrl_o.sys_dret_insn, ctrl_o.sys_wfi_insn, ctrl_o.sys_fencei_insn}))
      else $error("sys_decoder: more than one system kind bit set");
  end

endmodule

// File: logic/alu_lsu_decoder.sv
//////////////////////////////////////////////////
// alu / lsu decoder
// jumps, branches, loads, stores, lui, auipc,
// op-imm and op into the control bundle
//////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_lsu_decoder import rv32_decode_pkg::*; (
  input  logic [INSTR_W-1:0] instr_rdata_i,
  output logic               match_o,  // opcode is in one of our groups
  output decoder_ctrl_t      ctrl_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  always_comb begin
    ctrl_o              = DECODER_CTRL_ILLEGAL;
    ctrl_o.illegal_insn = 1'b0;  // start from an empty bundle
    match_o             = 1'b1;

    unique case (instr_rdata_i[6:0])
      //////////////////////////////////////////////////
      // control transfer
      OPCODE_JAL: begin
        ctrl_o.alu_en  = 1'b1;  // alu forms the link address
        ctrl_o.alu_jmp = 1'b1;
        ctrl_o.rf_we   = 1'b1;
      end

      OPCODE_JALR: begin
        if (funct3 != 3'b000) begin
          ctrl_o = DECODER_CTRL_ILLEGAL;
        end else begin
          ctrl_o.alu_en   = 1'b1;
          ctrl_o.alu_jmp  = 1'b1;
          ctrl_o.alu_jmpr = 1'b1;  // target from rs1, hazard check needs it
          ctrl_o.rf_we    = 1'b1;
          ctrl_o.rf_re[0] = 1'b1;
        end
      end

      OPCODE_BRANCH: begin
        ctrl_o.alu_en  = 1'b1;
        ctrl_o.alu_bch = 1'b1;
        ctrl_o.rf_re   = 2'b11;  // compare rs1 with rs2
        unique case (funct3)
          3'b000:  ctrl_o.alu_operator = ALU_EQ;
          3'b001:  ctrl_o.alu_operator = ALU_NE;
          3'b100:  ctrl_o.alu_operator = ALU_LT;
          3'b101:  ctrl_o.alu_operator = ALU_GE;
          3'b110:  ctrl_o.alu_operator = ALU_LTU;
          3'b111:  ctrl_o.alu_operator = ALU_GEU;
          default: ctrl_o = DECODER_CTRL_ILLEGAL;  // funct3 2 and 3 unused
        endcase
      end

      //////////////////////////////////////////////////
      // load / store
      OPCODE_LOAD: begin
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.rf_re[0] = 1'b1;          // base address
        ctrl_o.lsu_size = funct3[1:0];
        ctrl_o.lsu_sext = !funct3[2];    // lbu/lhu zero extend
        // ld, and the two reserved unsigned sizes
        if ((funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111)) begin
          ctrl_o = DECODER_CTRL_ILLEGAL;
        end
      end

      OPCODE_STORE: begin
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.lsu_we   = 1'b1;
        ctrl_o.rf_re    = 2'b11;         // base and write data
        ctrl_o.lsu_size = funct3[1:0];
        if (funct3[2] || (funct3[1:0] == 2'b11)) begin
          ctrl_o = DECODER_CTRL_ILLEGAL;
        end
      end

      //////////////////////////////////////////////////
      // alu
      OPCODE_LUI, OPCODE_AUIPC: begin
        ctrl_o.alu_en = 1'b1;  // imm + zero or imm + pc, both an add
        ctrl_o.rf_we  = 1'b1;
      end

      OPCODE_OPIMM: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.rf_re[0] = 1'b1;
        unique case (funct3)
          3'b000: ctrl_o.alu_operator = ALU_ADD;
          3'b010: ctrl_o.alu_operator = ALU_SLT;
          3'b011: ctrl_o.alu_operator = ALU_SLTU;
          3'b100: ctrl_o.alu_operator = ALU_XOR;
          3'b110: ctrl_o.alu_operator = ALU_OR;
          3'b111: ctrl_o.alu_operator = ALU_AND;
          3'b001: begin
            ctrl_o.alu_operator = ALU_SLL;
            if (funct7 != 7'h00) ctrl_o = DECODER_CTRL_ILLEGAL;
          end
          default: begin  // 101, srli or srai by funct7
            if (funct7 == 7'h00) begin
              ctrl_o.alu_operator = ALU_SRL;
            end else if (funct7 == 7'h20) begin
              ctrl_o.alu_operator = ALU_SRA;
            end else begin
              ctrl_o = DECODER_CTRL_ILLEGAL;
            end
          end
        endcase
      end

      OPCODE_OP: begin
        ctrl_o.alu_en   = 1'b1;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.rf_re[0] = 1'b1;
        ctrl_o.rf_re[1] = !instr_rdata_i[28];
        unique case ({funct7, funct3})
          {7'h00, 3'b000}: ctrl_o.alu_operator = ALU_ADD;
          {7'h20, 3'b000}: ctrl_o.alu_operator = ALU_SUB;
          {7'h00, 3'b001}: ctrl_o.alu_operator = ALU_SLL;
          {7'h00, 3'b010}: ctrl_o.alu_operator = ALU_SLT;
          {7'h00, 3'b011}: ctrl_o.alu_operator = ALU_SLTU;
          {7'h00, 3'b100}: ctrl_o.alu_operator = ALU_XOR;
          {7'h00, 3'b101}: ctrl_o.alu_operator = ALU_SRL;
          {7'h20, 3'b101}: ctrl_o.alu_operator = ALU_SRA;
          {7'h00, 3'b110}: ctrl_o.alu_operator = ALU_OR;
          {7'h00, 3'b111}: ctrl_o.alu_operator = ALU_AND;
          default:         ctrl_o = DECODER_CTRL_ILLEGAL;  // m-ext and unknown pairs
        endcase
      end

      default: match_o = 1'b0;  // left to the sys decoder
    endcase

    // execute issues to one unit per instruction
    assert (!(ctrl_o.alu_en && ctrl_o.lsu_en))
      else $error("alu_lsu_decoder: alu and lsu both enabled");
  end

endmodule

// File: logic/rvc_checker.sv
//////////////////////////////////////////////////
// rvc checker
// spots compressed words and flags reserved or
// unsupported rvc encodings, no expansion
//////////////////////////////////////////////////

`timescale 1ns/1ps

module rvc_checker import rv32_decode_pkg::*; (
  input  logic [INSTR_W-1:0] instr_rdata_i,  // raw fetched word
  output logic               rvc_o,          // low bits not 11
  output logic               illegal_o       // reserved or unsupported form
);

  logic [2:0] funct3;  // rvc funct3 sits in [15:13]
  logic [4:0] rd;      // rd/rs1 field
  logic [4:0] rs2;

  assign funct3 = instr_rdata_i[15:13];
  assign rd     = instr_rdata_i[11:7];
  assign rs2    = instr_rdata_i[6:2];

  always_comb begin
    rvc_o     = (instr_rdata_i[1:0] != 2'b11);
    illegal_o = 1'b0;

    unique case (instr_rdata_i[1:0])
      // quadrant 0
      2'b00: begin
        unique case (funct3)
          3'b000:         illegal_o = (instr_rdata_i[12:5] == 8'h00);  // c.addi4spn, zero imm
          3'b010, 3'b110: illegal_o = 1'b0;                            // c.lw, c.sw
          default:        illegal_o = 1'b1;  // fp loads/stores and reserved 100
        endcase
      end

      // quadrant 1
      2'b01: begin
        unique case (funct3)
          // c.lui / c.addi16sp need a nonzero imm
          3'b011: illegal_o = ({instr_rdata_i[12], rs2} == 6'h00);
          3'b100: begin
            // srli/srai shamt[5] and the subw/addw row, c.andi is fine
            if (instr_rdata_i[11:10] != 2'b10) begin
              illegal_o = instr_rdata_i[12];
            end
          end
          default: illegal_o = 1'b0;
        endcase
      end

      // quadrant 2
      2'b10: begin
        unique case (funct3)
          3'b000:  illegal_o = instr_rdata_i[12];  // c.slli shamt[5] is rv64 only
          3'b010:  illegal_o = (rd == 5'd0);       // c.lwsp to x0
          3'b100:  illegal_o = !instr_rdata_i[12] && (rs2 == 5'd0) && (rd == 5'd0);  // c.jr x0
          3'b110:  illegal_o = 1'b0;               // c.swsp
          default: illegal_o = 1'b1;               // fp sp-relative forms
        endcase
      end

      default: illegal_o = 1'b0;  // full-size word, not ours
    endcase

    // the top relies on a 32-bit word never reporting rvc illegal
    assert (rvc_o || !illegal_o)
      else $error("rvc_checker: illegal_o raised for a non-compressed word");
  end

endmodule

// File: logic/rv32_decode_pkg.sv
//////////////////////////////////////////////////
// rv32 decode package
// opcodes, alu and csr operators and the control
// bundle shared by the decode stage and its decoders
//////////////////////////////////////////////////

package rv32_decode_pkg;

  localparam int unsigned INSTR_W = 32;  // fetched word width

  //////////////////////////////////////////////////
  // major opcodes, instr[6:0]
  localparam logic [6:0] OPCODE_LUI    = 7'h37;
  localparam logic [6:0] OPCODE_AUIPC  = 7'h17;
  localparam logic [6:0] OPCODE_JAL    = 7'h6f;
  localparam logic [6:0] OPCODE_JALR   = 7'h67;
  localparam logic [6:0] OPCODE_BRANCH = 7'h63;
  localparam logic [6:0] OPCODE_LOAD   = 7'h03;
  localparam logic [6:0] OPCODE_STORE  = 7'h23;
  localparam logic [6:0] OPCODE_OPIMM  = 7'h13;
  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_FENCE  = 7'h0f;
  localparam logic [6:0] OPCODE_SYSTEM = 7'h73;

  //////////////////////////////////////////////////
  // operator encodings
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR,  ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,                         // set-less-than results
    ALU_EQ,  ALU_NE,  ALU_LT, ALU_GE, ALU_LTU, ALU_GEU  // branch compares
  } alu_op_e;

  typedef enum logic [1:0] {
    CSR_OP_READ,   // no write side effect
    CSR_OP_WRITE,
    CSR_OP_SET,
    CSR_OP_CLEAR
  } csr_op_e;

  //////////////////////////////////////////////////
  // control bundle handed to execute
  typedef struct packed {
    logic       illegal_insn;
    logic       alu_en;
    alu_op_e    alu_operator;
    logic       alu_bch;          // conditional branch
    logic       alu_jmp;          // jal or jalr
    logic       alu_jmpr;         // jump target from rs1
    logic       rf_we;
    logic [1:0] rf_re;            // [0] rs1, [1] rs2
    logic       lsu_en;
    logic       lsu_we;
    logic [1:0] lsu_size;         // byte, half, word
    logic       lsu_sext;
    logic       csr_en;
    csr_op_e    csr_op;
    logic       sys_en;
    logic       sys_ecall_insn;
    logic       sys_ebrk_insn;
    logic       sys_mret_insn;
    logic       sys_dret_insn;
    logic       sys_wfi_insn;
    logic       sys_fencei_insn;  // fence and fence.i both flush
  } decoder_ctrl_t;

  // empty bundle with only the illegal flag raised
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL = '{
    illegal_insn: 1'b1,
    alu_operator: ALU_ADD,
    csr_op:       CSR_OP_READ,
    default:      '0
  };

endpackage
